// File: src/ram_test_pkg.sv
`default_nettype none

package ram_test_pkg;

    //////////////////////////////
    // Memory geometry.
    //////////////////////////////
    localparam int ADDR_W    = 24;  // Bank 2 + row 13 + column 9.
    localparam int WORD_W    = 16;  // One SDRAM word.
    localparam int BURST_LEN = 4;   // Words per burst.
    localparam int ADDR_STEP = 4;   // Next burst starts one burst further on.

    //////////////////////////////
    // Report and UART framing.
    //////////////////////////////
    localparam logic [7:0] ERR_BYTE = 8'hEE;  // Sent in place of a bad word's byte.
    localparam int STOP_BITS  = 2;
    localparam int FRAME_BITS = 11;  // Start + 8 data + 2 stop.

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // Word 0 sits in the low bits.
    typedef logic [BURST_LEN-1:0][WORD_W-1:0] burst_t;

    // Self-test sequencer states.
    typedef enum logic [2:0] {
        WRITE,      // Burst write, request held until done.
        READ,       // Burst read back.
        REPORT,     // Start one UART frame.
        SEND,       // Frame on the line.
        PAUSE,      // Idle gap between bursts.
        FAIL,       // Mismatch seen, halted.
        FINISHED    // All bursts checked.
    } seq_state_e;

endpackage

`default_nettype wire

// File: src/report_if.sv
`timescale 1ns/1ns
`default_nettype none

// Read-back results from checker to sequencer.
interface report_if;

    logic       capture;      // Latch read burst, restart byte index.
    logic       next_byte;    // Step to the following report byte.
    logic [7:0] report_byte;  // Byte to send.
    logic       byte_bad;     // Current word failed compare.
    logic       last_byte;    // Low byte of the last word.

    // Checker side.
    modport check (
        input  capture,
        input  next_byte,
        output report_byte,
        output byte_bad,
        output last_byte
    );

    // Sequencer side.
    modport sequencer (
        output capture,
        output next_byte,
        input  report_byte,
        input  byte_bad,
        input  last_byte
    );

endinterface

`default_nettype wire

// File: src/burst_pattern_gen.sv
`timescale 1ns/1ns
`default_nettype none

module burst_pattern_gen
    import ram_test_pkg::*;
#(
    parameter int BURST_COUNT = 96000  // Bursts in one full run.
) (
    input  wire    clk_133MHz_210,
    input  wire    rst_n,
    input  wire    advance,       // Step to next burst.
    output addr_t  mem_addr,      // Burst start address.
    output burst_t wr_data,       // Pattern words to write.
    output logic   last_burst     // Current burst is the final one.
);

    // Wide enough for BURST_COUNT itself.
    localparam int CNT_W = $clog2(BURST_COUNT + 1);

    logic [CNT_W-1:0] burst_cnt;  // Bursts done so far.
    word_t            pattern;    // Value of every word in this burst.

    //////////////////////////////
    // Burst registers.
    //////////////////////////////
    // Only move on advance, so address and data hold through a request.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            burst_cnt <= '0;
            mem_addr  <= '0;
            pattern   <= '0;
        end else if (advance) begin
            burst_cnt <= burst_cnt + 1'b1;
            mem_addr  <= mem_addr + ADDR_W'(ADDR_STEP);  // Next four-word slot.
            pattern   <= pattern + 1'b1;                 // Wraps at 64K.
        end
    end

    // All four words carry the same value.
    assign wr_data = {BURST_LEN{pattern}};

    // Sequencer stops advancing here.
    assign last_burst = (burst_cnt == CNT_W'(BURST_COUNT - 1));

endmodule

`default_nettype wire

// File: src/readback_checker.sv
`timescale 1ns/1ns
`default_nettype none

module readback_checker
    import ram_test_pkg::*;
(
    input  wire            clk_133MHz_210,
    input  wire            rst_n,
    input  wire burst_t    rd_data,   // Valid with rd_done.
    input  wire burst_t    wr_data,   // What was written.
    report_if.check        report
);

    // Two bytes per word.
    localparam int NUM_BYTES = 2 * BURST_LEN;
    localparam int IDX_W     = $clog2(NUM_BYTES);

    burst_t           rd_buf;     // Captured read burst.
    logic [IDX_W-1:0] byte_idx;   // 0..7, hi then lo per word.
    logic [IDX_W-2:0] word_sel;   // Word under test.
    word_t            rd_word;
    word_t            wr_word;
    logic             word_ok;

    //////////////////////////////
    // Byte index.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            byte_idx <= '0;
        end else if (report.capture) begin
            byte_idx <= '0;                      // New burst, start at word 0 high.
        end else if (report.next_byte && !report.last_byte) begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

    // Read data store.
    always_ff @(posedge clk_133MHz_210) begin
        if (report.capture) begin
            rd_buf <= rd_data;
        end
    end

    //////////////////////////////
    // Compare and byte select.
    //////////////////////////////
    assign word_sel = byte_idx[IDX_W-1:1];
    assign rd_word  = rd_buf[word_sel];
    assign wr_word  = wr_data[word_sel];
    assign word_ok  = (rd_word == wr_word);

    always_comb begin
        if (!word_ok) begin
            report.report_byte = ERR_BYTE;          // Bad word, flag it.
        end else if (byte_idx[0]) begin
            report.report_byte = rd_word[7:0];      // Odd index, low byte.
        end else begin
            report.report_byte = rd_word[WORD_W-1:8];
        end
    end

    assign report.byte_bad  = !word_ok;
    assign report.last_byte = (byte_idx == IDX_W'(NUM_BYTES - 1));  // Word 3 low.

endmodule

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
    import ram_test_pkg::*;
#(
    parameter int BAUD_DIV = 1157  // 133.33 MHz / 115200.
) (
    input  wire       clk_133MHz_210,
    input  wire       rst_n,
    input  wire       tx_start,   // Load and send one byte.
    input  wire [7:0] tx_byte,
    output logic      tx_busy,    // Frame in progress.
    output logic      uart_txd
);

    localparam int BAUD_W = $clog2(BAUD_DIV);
    localparam int BIT_W  = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] frame;     // Bit 0 is on the line.
    logic [BAUD_W-1:0]     baud_cnt;  // Clocks into current bit.
    logic [BIT_W-1:0]      bit_cnt;   // Bit of the frame being sent.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            frame    <= '1;                    // Line idles high.
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // Stops, data, start bit at the bottom.
                frame    <= {{STOP_BITS{1'b1}}, tx_byte, 1'b0};
                baud_cnt <= '0;
                bit_cnt  <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (baud_cnt == BAUD_W'(BAUD_DIV - 1)) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[FRAME_BITS-1:1]};  // Next bit, fill idle.
            if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                bit_cnt <= '0;
                tx_busy <= 1'b0;                        // Last stop bit done.
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign uart_txd = frame[0];

endmodule

`default_nettype wire

// File: src/test_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module test_sequencer
    import ram_test_pkg::*;
#(
    parameter int PAUSE_CYCLES = 2222222  // Gap between bursts.
) (
    input  wire         clk_133MHz_210,
    input  wire         rst_n,
    input  wire         wr_done,     // One-cycle pulse.
    input  wire         rd_done,     // One-cycle pulse.
    input  wire         last_burst,
    input  wire         tx_busy,
    output logic        wr_req,      // Held until wr_done.
    output logic        rd_req,      // Held until rd_done.
    output logic        advance,     // Next burst pattern.
    output logic        tx_start,
    output logic [7:0]  tx_byte,
    output logic        led,         // Error halt.
    output logic        finished,
    report_if.sequencer report
);

    localparam int PAUSE_W = $clog2(PAUSE_CYCLES + 1);

    seq_state_e         state;
    logic [PAUSE_W-1:0] pause_cnt;
    logic               pause_done;  // Last clock of the gap.

    assign pause_done = (pause_cnt == PAUSE_W'(PAUSE_CYCLES - 1));

    //////////////////////////////
    // Main FSM.
    //////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state     <= WRITE;
            wr_req    <= 1'b0;
            rd_req    <= 1'b0;
            pause_cnt <= '0;
        end else begin
            case (state)
                WRITE: begin
                    if (wr_done) begin
                        wr_req <= 1'b0;             // Drop on the clock after done.
                        state  <= READ;
                    end else begin
                        wr_req <= 1'b1;
                    end
                end
                READ: begin
                    if (rd_done) begin
                        rd_req <= 1'b0;
                        state  <= REPORT;           // Checker latches this cycle.
                    end else begin
                        rd_req <= 1'b1;
                    end
                end
                REPORT: state <= SEND;              // Frame loads now.
                SEND: begin
                    // Busy is already up on the first SEND clock.
                    if (!tx_busy) begin
                        if (report.byte_bad) begin
                            state <= FAIL;          // Error byte is out, halt.
                        end else if (report.last_byte) begin
                            state <= PAUSE;
                        end else begin
                            state <= REPORT;
                        end
                    end
                end
                PAUSE: begin
                    if (pause_done) begin
                        pause_cnt <= '0;
                        if (last_burst) begin
                            state <= FINISHED;
                        end else begin
                            state <= WRITE;
                        end
                    end else begin
                        pause_cnt <= pause_cnt + 1'b1;
                    end
                end
                FAIL:     state <= FAIL;            // Stays until reset.
                FINISHED: state <= FINISHED;
                default:  state <= WRITE;
            endcase
        end
    end

    //////////////////////////////
    // Strobes and status.
    //////////////////////////////
    assign report.capture   = (state == READ) && rd_done;
    assign report.next_byte = (state == SEND) && !tx_busy &&
                              !report.byte_bad && !report.last_byte;

    assign tx_start = (state == REPORT);
    assign tx_byte  = report.report_byte;   // Held steady until next_byte.
    assign advance  = (state == PAUSE) && pause_done && !last_burst;
    assign led      = (state == FAIL);
    assign finished = (state == FINISHED);

endmodule

`default_nettype wire

// File: src/ram_self_test.sv
`timescale 1ns/1ns
`default_nettype none

module ram_self_test
    import ram_test_pkg::*;
#(
    parameter int BAUD_DIV     = 1157,     // 115200 baud at 133 MHz.
    parameter int PAUSE_CYCLES = 2222222,  // About 16.7 ms between bursts.
    parameter int BURST_COUNT  = 96000     // Bursts before finishing.
) (
    input  wire         clk_133MHz_210,
    input  wire         rst_n,

    // Burst memory controller side.
    output addr_t       mem_addr,
    output burst_t      wr_data,
    output logic        wr_req,
    output logic        rd_req,
    input  wire         wr_done,
    input  wire         rd_done,
    input  wire burst_t rd_data,

    // Status.
    output logic        uart_txd,
    output logic        led,         // Halted on mismatch.
    output logic        finished
);

    logic       advance;
    logic       last_burst;
    logic       tx_start;
    logic       tx_busy;
    logic [7:0] tx_byte;

    report_if report ();  // Checker to sequencer results.

    //////////////////////////////
    // Pattern and check.
    //////////////////////////////
    burst_pattern_gen #(
        .BURST_COUNT(BURST_COUNT)
    ) burst_pattern_gen_inst (
        .clk_133MHz_210(clk_133MHz_210),
        .rst_n         (rst_n),
        .advance       (advance),
        .mem_addr      (mem_addr),
        .wr_data       (wr_data),
        .last_burst    (last_burst)
    );

    readback_checker readback_checker_inst (
        .clk_133MHz_210(clk_133MHz_210),
        .rst_n         (rst_n),
        .rd_data       (rd_data),
        .wr_data       (wr_data),      // Compared against the live pattern.
        .report        (report.check)
    );

    //////////////////////////////
    // Control and UART.
    //////////////////////////////
    test_sequencer #(
        .PAUSE_CYCLES(PAUSE_CYCLES)
    ) test_sequencer_inst (
        .clk_133MHz_210(clk_133MHz_210),
        .rst_n         (rst_n),
        .wr_done       (wr_done),
        .rd_done       (rd_done),
        .last_burst    (last_burst),
        .tx_busy       (tx_busy),
        .wr_req        (wr_req),
        .rd_req        (rd_req),
        .advance       (advance),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .led           (led),
        .finished      (finished),
        .report        (report.sequencer)
    );

    uart_tx #(
        .BAUD_DIV(BAUD_DIV)
    ) uart_tx_inst (
        .clk_133MHz_210(clk_133MHz_210),
        .rst_n         (rst_n),
        .tx_start      (tx_start),
        .tx_byte       (tx_byte),
        .tx_busy       (tx_busy),
        .uart_txd      (uart_txd)
    );

endmodule

`default_nettype wire

// File: verif/burst_ram_model.sv
`timescale 1ns/1ns
`default_nettype none

// Burst memory behind the request/done handshake.
module burst_ram_model
    import ram_test_pkg::*;
(
    input  wire         clk_133MHz_210,
    input  wire         wr_req,
    input  wire         rd_req,
    input  wire addr_t  mem_addr,
    input  wire burst_t wr_data,
    input  wire         corrupt_en,    // Damage reads from corrupt_addr.
    input  wire addr_t  corrupt_addr,
    input  wire [1:0]   corrupt_word,
    input  wire [3:0]   corrupt_bit,
    output logic        wr_done,
    output logic        rd_done,
    output burst_t      rd_data
);

    burst_t      mem [addr_t];  // Sparse, one entry per burst.
    burst_t      rd_burst;
    int unsigned latency;

    //////////////////////////////
    // One done pulse per request.
    //////////////////////////////
    initial begin
        wr_done = 1'b0;
        rd_done = 1'b0;
        rd_data = '0;
        forever begin
            @(posedge clk_133MHz_210);
            if (wr_req || rd_req) begin
                latency = $urandom_range(10, 1);             // 1 to 10 clocks.
                repeat (latency - 1) @(posedge clk_133MHz_210);
                #1;
                if (wr_req) begin
                    mem[mem_addr] = wr_data;
                    wr_done       = 1'b1;
                end else begin
                    if (mem.exists(mem_addr)) begin
                        rd_burst = mem[mem_addr];
                    end else begin
                        // Never written, tagged with its own address.
                        rd_burst = {8'hA5, mem_addr, ~mem_addr, 8'h5A};
                    end
                    if (corrupt_en && mem_addr == corrupt_addr) begin
                        rd_burst[corrupt_word][corrupt_bit] = ~rd_burst[corrupt_word][corrupt_bit];
                    end
                    rd_data = rd_burst;                      // Valid with rd_done.
                    rd_done = 1'b1;
                end
                @(posedge clk_133MHz_210);                   // DUT sees done here.
                #1;
                wr_done = 1'b0;
                rd_done = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_ram_self_test.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ram_self_test
    import ram_test_pkg::*;
();

    localparam int BAUD_DIV       = 8;
    localparam int PAUSE_CYCLES   = 20;
    localparam int BURSTS         = 6;
    localparam int FRAME_CLKS     = FRAME_BITS * BAUD_DIV;  // 88 clocks a byte.
    localparam int TIMEOUT_CYCLES =
        2 * BURSTS * (8 * FRAME_CLKS + PAUSE_CYCLES + 40) * 2;

    logic       clk_133MHz_210 = 1'b0;
    logic       rst_n = 1'b0;
    logic       wr_req, rd_req, wr_done, rd_done, uart_txd, led, finished;
    addr_t      mem_addr, prev_addr, corrupt_addr;
    burst_t     wr_data, rd_data, prev_data;
    logic       corrupt_en = 1'b0;
    logic       phase_b = 1'b0;              // Second run, one bad word.
    logic [1:0] corrupt_word;
    logic [3:0] corrupt_bit;
    logic       prev_wr_req, prev_rd_req, prev_wr_done, prev_rd_done;
    logic [7:0] rx_shift;
    logic [7:0] rx_bytes [$];                // Decoded off uart_txd.
    logic [7:0] exp_bytes [$];
    int         errors, tests_passed, tests_failed, cycle_cnt;
    int         wr_seen, rd_seen, wr_starts, rd_starts;
    int         corrupt_burst, reqs_mark, bytes_mark;
    int         test_errs [1:6];

    always #4 clk_133MHz_210 = ~clk_133MHz_210;   // 8 ns period.

    ram_self_test #(
        .BAUD_DIV    (BAUD_DIV),
        .PAUSE_CYCLES(PAUSE_CYCLES),
        .BURST_COUNT (BURSTS)
    ) ram_self_test_inst (.*);

    burst_ram_model burst_ram_model_inst (.*);

    task wrong_value(input int t, input string sig,
                     input logic [63:0] got, input logic [63:0] exp);
        $display("MISMATCH %s: got %h expected %h (test %0d, %0t)", sig, got, exp, t, $time);
        errors++;
        test_errs[t]++;
    endtask

    task fault(input int t, input string what);
        $display("ERROR test %0d at %0t: %s", t, $time, what);
        errors++;
        test_errs[t]++;
    endtask

    task end_test(input int t, input string name);
        if (test_errs[t] == 0) begin
            tests_passed++;
            $display("PASS test %0d: %s", t, name);
        end else begin
            tests_failed++;
            $display("FAIL test %0d: %s, %0d errors", t, name, test_errs[t]);
        end
    endtask

    // Two cycles of reset, then idle outputs before the first request.
    task apply_reset(input string phase);
        wr_seen      = 0;
        rd_seen      = 0;
        wr_starts    = 0;
        rd_starts    = 0;
        test_errs[1] = 0;
        rx_bytes.delete();
        exp_bytes.delete();
        @(posedge clk_133MHz_210);
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk_133MHz_210);
        #1 rst_n = 1'b1;
        @(negedge clk_133MHz_210);
        if (wr_req !== 1'b0) wrong_value(1, "wr_req", 64'(wr_req), 64'd0);
        if (rd_req !== 1'b0) wrong_value(1, "rd_req", 64'(rd_req), 64'd0);
        if (led !== 1'b0) wrong_value(1, "led", 64'(led), 64'd0);
        if (finished !== 1'b0) wrong_value(1, "finished", 64'(finished), 64'd0);
        if (uart_txd !== 1'b1) wrong_value(1, "uart_txd", 64'(uart_txd), 64'd1);
        end_test(1, {"reset values, ", phase});
    endtask

    task add_expected(input int n, input int words);
        for (int w = 0; w < words; w++) begin
            exp_bytes.push_back(8'(n >> 8));            // High byte first.
            exp_bytes.push_back(8'(n));
        end
    endtask

    task compare_bytes(input int t);
        if (rx_bytes.size() != exp_bytes.size())
            wrong_value(t, "uart byte count", 64'(rx_bytes.size()), 64'(exp_bytes.size()));
        for (int i = 0; i < rx_bytes.size() && i < exp_bytes.size(); i++) begin
            if (rx_bytes[i] !== exp_bytes[i])
                wrong_value(t, $sformatf("uart_txd byte %0d", i),
                            64'(rx_bytes[i]), 64'(exp_bytes[i]));
        end
    endtask

    ///////////////////////////////
    // Monitors.
    ///////////////////////////////
    always @(posedge clk_133MHz_210) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, test never completed", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // Handshake rules and pattern, sampled mid-cycle.
    always @(negedge clk_133MHz_210) begin
        if (rst_n) begin
            if (wr_req && rd_req) fault(6, "wr_req and rd_req high together");
            if (prev_wr_req && !wr_req && !prev_wr_done) fault(6, "wr_req dropped before wr_done");
            if (prev_rd_req && !rd_req && !prev_rd_done) fault(6, "rd_req dropped before rd_done");
            if (prev_wr_done && wr_req) fault(6, "wr_req still high after its done cycle");
            if (prev_rd_done && rd_req) fault(6, "rd_req still high after its done cycle");
            if (((prev_wr_req && wr_req) || (prev_rd_req && rd_req)) &&
                (mem_addr != prev_addr || wr_data != prev_data))
                fault(6, "address or write data moved during a request");
            if (wr_req && !prev_wr_req) wr_starts++;
            if (rd_req && !prev_rd_req) rd_starts++;
            if (wr_req && wr_done) begin
                if (mem_addr != addr_t'(ADDR_STEP * wr_seen))
                    wrong_value(phase_b ? 5 : 2, "mem_addr",
                                64'(mem_addr), 64'(ADDR_STEP * wr_seen));
                if (wr_data != {BURST_LEN{word_t'(wr_seen)}})
                    wrong_value(phase_b ? 5 : 2, "wr_data",
                                wr_data, {BURST_LEN{word_t'(wr_seen)}});
                wr_seen++;
            end
            if (rd_req && rd_done) begin
                if (!phase_b && rd_data != {BURST_LEN{word_t'(rd_seen)}})
                    wrong_value(2, "rd_data", rd_data, {BURST_LEN{word_t'(rd_seen)}});
                rd_seen++;
            end
        end
        prev_wr_req  = wr_req;
        prev_rd_req  = rd_req;
        prev_wr_done = wr_done;
        prev_rd_done = rd_done;
        prev_addr    = mem_addr;
        prev_data    = wr_data;
    end

    // UART receiver, samples mid-bit.
    always begin
        @(negedge clk_133MHz_210);
        if (uart_txd === 1'b0) begin
            repeat (BAUD_DIV / 2) @(negedge clk_133MHz_210);
            if (uart_txd !== 1'b0) fault(phase_b ? 5 : 3, "UART start bit not low mid-bit");
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                rx_shift[i] = uart_txd;                  // LSB first.
            end
            for (int i = 0; i < STOP_BITS; i++) begin
                repeat (BAUD_DIV) @(negedge clk_133MHz_210);
                if (uart_txd !== 1'b1) fault(phase_b ? 5 : 3, "UART stop bit not high");
            end
            rx_bytes.push_back(rx_shift);
        end
    end

    ///////////////////////////////
    // Two runs.
    ///////////////////////////////
    initial begin
        void'($urandom(28));
        corrupt_addr = '0;
        corrupt_word = '0;
        corrupt_bit  = '0;
        apply_reset("clean run");
        while (finished !== 1'b1) @(negedge clk_133MHz_210);
        reqs_mark = wr_starts + rd_starts;
        repeat (2 * FRAME_CLKS) @(negedge clk_133MHz_210);
        if (wr_seen != BURSTS) wrong_value(2, "write count", 64'(wr_seen), 64'(BURSTS));
        if (rd_seen != BURSTS) wrong_value(2, "read count", 64'(rd_seen), 64'(BURSTS));
        end_test(2, "write pattern and read-back");
        for (int n = 0; n < BURSTS; n++) add_expected(n, BURST_LEN);
        compare_bytes(3);
        end_test(3, "UART bytes and framing");
        if (finished !== 1'b1) wrong_value(4, "finished", 64'(finished), 64'd1);
        if (led !== 1'b0) wrong_value(4, "led", 64'(led), 64'd0);
        if (wr_starts + rd_starts != reqs_mark) fault(4, "request after the last report byte");
        if (wr_starts != BURSTS) wrong_value(4, "write requests", 64'(wr_starts), 64'(BURSTS));
        end_test(4, "end of clean run");

        corrupt_burst = $urandom_range(BURSTS - 1, 0);  // Pick burst, word and bit.
        corrupt_word  = 2'($urandom_range(BURST_LEN - 1, 0));
        corrupt_bit   = 4'($urandom_range(WORD_W - 1, 0));
        corrupt_addr  = addr_t'(ADDR_STEP * corrupt_burst);
        corrupt_en    = 1'b1;
        phase_b       = 1'b1;
        $display("Corrupting burst %0d word %0d bit %0d", corrupt_burst, corrupt_word, corrupt_bit);
        apply_reset("corrupted run");
        while (led !== 1'b1) @(negedge clk_133MHz_210);
        reqs_mark  = wr_starts + rd_starts;
        bytes_mark = rx_bytes.size();
        repeat (3 * FRAME_CLKS) @(negedge clk_133MHz_210);
        for (int n = 0; n < corrupt_burst; n++) add_expected(n, BURST_LEN);
        add_expected(corrupt_burst, corrupt_word);
        exp_bytes.push_back(ERR_BYTE);
        compare_bytes(5);
        if (led !== 1'b1) wrong_value(5, "led", 64'(led), 64'd1);
        if (finished !== 1'b0) wrong_value(5, "finished", 64'(finished), 64'd0);
        if (wr_starts + rd_starts != reqs_mark) fault(5, "request after the error halt");
        if (rx_bytes.size() != bytes_mark) fault(5, "UART byte after the error halt");
        end_test(5, "error byte and halt");
        end_test(6, "request handshake");

        $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/ram_test_pkg.sv
src/report_if.sv
src/burst_pattern_gen.sv
src/readback_checker.sv
src/uart_tx.sv
src/test_sequencer.sv
src/ram_self_test.sv
verif/burst_ram_model.sv
verif/tb_ram_self_test.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then scan the log.
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module tb_ram_self_test -f all.f -Mdir obj_dir -o vsim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if grep -q "sim failed" "$LOG"; then
    exit 1
fi
exit 0
